/* Makefile */
SIM      = verilator
SIMFLAGS = --binary --timing --assert -Wno-fatal
TOP      = tb_a2_disk
FILELIST = sim.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

# Pass only if the run printed the pass line
test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJDIR)

/* a2_bus_pkg.sv */
// ==================================================
// Block bus request layout and drive unit codes
// ==================================================

`include "a2_params.svh"

package a2_bus_pkg;

	// ==================================================
	// Drive units
	// ==================================================

	// Same numbering as the image slots of the host
	typedef enum logic [1:0] {
		unit_floppy1 = 2'd0,
		unit_hdd     = 2'd1,
		unit_floppy2 = 2'd2
	} drive_unit_e;

	// ==================================================
	// Master request
	// ==================================================

	// Classic cycle, held until the responder acks
	// Command only, no data phase
	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		drive_unit_e          unit;
		logic [`A2_LBA_W-1:0] adr;
	} blk_req_t;

endpackage

/* a2_disk_top.sv */
// ==================================================
// Storage request side, two floppies and hard disk
// ==================================================

`timescale 1ns/100ps
`include "a2_params.svh"

module a2_disk_top (
	input  logic                     clk_sys,
	input  logic                     dd_reset,
	input  a2_drive_pkg::mount_evt_t mount,
	input  logic                     hdd_read,
	input  logic                     hdd_write,
	input  logic [`A2_LBA_W-1:0]     hdd_sector,
	input  a2_drive_pkg::track_t     track1,
	input  a2_drive_pkg::track_t     track2,
	output a2_bus_pkg::blk_req_t     blk,
	input  logic                     blk_ack,
	output logic                     cpu_wait,
	output logic                     hdd_mounted,
	output logic                     hdd_protect,
	output logic [1:0]               disk_busy,
	output logic [1:0]               disk_ready
);
	import a2_bus_pkg::*;

	// Master slots indexed by drive unit
	blk_req_t             mreq [`A2_UNITS];
	logic [`A2_UNITS-1:0] mack;

	floppy_track_fetch i_floppy1 (
		.clk_sys  (clk_sys),
		.dd_reset (dd_reset),
		.unit     (unit_floppy1),
		.mount    (mount),
		.track    (track1),
		.req      (mreq[unit_floppy1]),
		.ack      (mack[unit_floppy1]),
		.busy     (disk_busy[0]),
		.ready    (disk_ready[0])
	);

	floppy_track_fetch i_floppy2 (
		.clk_sys  (clk_sys),
		.dd_reset (dd_reset),
		.unit     (unit_floppy2),
		.mount    (mount),
		.track    (track2),
		.req      (mreq[unit_floppy2]),
		.ack      (mack[unit_floppy2]),
		.busy     (disk_busy[1]),
		.ready    (disk_ready[1])
	);

	hdd_request i_hdd (
		.clk_sys     (clk_sys),
		.dd_reset    (dd_reset),
		.mount       (mount),
		.hdd_read    (hdd_read),
		.hdd_write   (hdd_write),
		.hdd_sector  (hdd_sector),
		.req         (mreq[unit_hdd]),
		.ack         (mack[unit_hdd]),
		.cpu_wait    (cpu_wait),
		.hdd_mounted (hdd_mounted),
		.hdd_protect (hdd_protect)
	);

	blk_arbiter i_arbiter (
		.clk_sys  (clk_sys),
		.dd_reset (dd_reset),
		.req_in   (mreq),
		.ack_in   (blk_ack),
		.req_out  (blk),
		.ack_out  (mack)
	);

endmodule

/* a2_drive_pkg.sv */
// ==================================================
// Mount events, track numbers, drive FSM states
// ==================================================

`include "a2_params.svh"

package a2_drive_pkg;

	// ==================================================
	// Host side events
	// ==================================================

	// One event names a single image slot
	// nonempty clear means the image was removed
	typedef struct packed {
		logic                    valid;
		a2_bus_pkg::drive_unit_e unit;
		logic                    nonempty;
		logic                    readonly;
	} mount_evt_t;

	// Head position from the disk controller
	typedef logic [`A2_TRACK_W-1:0] track_t;

	// ==================================================
	// Drive FSMs
	// ==================================================

	typedef enum logic {
		hdd_idle  = 1'b0,
		hdd_cycle = 1'b1
	} hdd_state_e;

	typedef enum logic [1:0] {
		fdd_empty  = 2'd0,
		fdd_fetch  = 2'd1,
		fdd_loaded = 2'd2
	} fdd_state_e;

endpackage

/* a2_params.svh */
// ==================================================
// Block bus and floppy geometry constants
// ==================================================

`ifndef A2_PARAMS_SVH
`define A2_PARAMS_SVH

// ==================================================
// Block bus
// ==================================================

// Block address as seen by the storage side
`define A2_LBA_W 32

// Bus masters, floppy 1, hard disk and floppy 2
`define A2_UNITS 3

// ==================================================
// Floppy geometry
// ==================================================

// Head position, 35 tracks fit with room to spare
`define A2_TRACK_W 6

// One nibble track spans 13 blocks of the image
`define A2_TRACK_BLOCKS 13

`endif

/* blk_arbiter.sv */
// ==================================================
// Round-robin arbiter for the shared block bus
// ==================================================

`timescale 1ns/100ps
`include "a2_params.svh"

module blk_arbiter (
	input  logic                 clk_sys,
	input  logic                 dd_reset,
	input  a2_bus_pkg::blk_req_t req_in [`A2_UNITS],
	input  logic                 ack_in,
	output a2_bus_pkg::blk_req_t req_out,
	output logic [`A2_UNITS-1:0] ack_out
);
	import a2_bus_pkg::*;

	logic [`A2_UNITS-1:0] req_vec;
	logic [`A2_UNITS-1:0] grant;
	logic [`A2_UNITS-1:0] pick;
	logic [1:0]           last_q;
	logic [1:0]           pick_idx;

	always_comb begin
		for (int i = 0; i < `A2_UNITS; i++) begin
			req_vec[i] = req_in[i].cyc && req_in[i].stb;
		end
	end

	// Walk from the farthest master back to the one right after last_q,
	// so the nearest requester wins
	always_comb begin
		int idx;
		pick     = '0;
		pick_idx = last_q;
		for (int k = `A2_UNITS; k >= 1; k--) begin
			idx = (int'(last_q) + k) % `A2_UNITS;
			if (req_vec[idx]) begin
				pick      = '0;
				pick[idx] = 1'b1;
				pick_idx  = 2'(idx);
			end
		end
	end

	// ==================================================
	// Grant register
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			grant  <= '0;
			last_q <= 2'(`A2_UNITS - 1);
		end else if (grant == '0) begin
			if (req_vec != '0) begin
				grant  <= pick;
				last_q <= pick_idx;
			end
		end else if (ack_in || !req_out.cyc) begin
			// Cycle ended or master withdrew its request
			grant <= '0;
		end
	end

	always_comb begin
		req_out = '0;
		for (int i = 0; i < `A2_UNITS; i++) begin
			if (grant[i])
				req_out = req_in[i];
		end
	end

	assign ack_out = grant & {`A2_UNITS{ack_in}};

	a_grant_onehot: assert property (@(posedge clk_sys) disable iff (dd_reset)
		$onehot0(grant));

	// Ack reaches one master, and only one that still requests
	a_ack_single: assert property (@(posedge clk_sys) disable iff (dd_reset)
		$onehot0(ack_out) && ((ack_out & ~req_vec) == '0));

endmodule

/* floppy_track_fetch.sv */
// ==================================================
// Floppy drive master, mount tracking and track fetch
// ==================================================

`timescale 1ns/100ps
`include "a2_params.svh"

module floppy_track_fetch (
	input  logic                     clk_sys,
	input  logic                     dd_reset,
	input  a2_bus_pkg::drive_unit_e  unit,
	input  a2_drive_pkg::mount_evt_t mount,
	input  a2_drive_pkg::track_t     track,
	output a2_bus_pkg::blk_req_t     req,
	input  logic                     ack,
	output logic                     busy,
	output logic                     ready
);
	import a2_bus_pkg::*;
	import a2_drive_pkg::*;

	fdd_state_e           state;
	track_t               cur_trk;
	logic                 refetch;
	logic                 own_evt;
	logic                 cyc_q;
	logic [`A2_LBA_W-1:0] adr_q;
	logic [`A2_LBA_W-1:0] trk_lba;

	assign own_evt = mount.valid && (mount.unit == unit);

	// First block of the track inside the image
	assign trk_lba = `A2_LBA_W'(track) * `A2_LBA_W'(`A2_TRACK_BLOCKS);

	// ==================================================
	// Drive FSM
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			state   <= fdd_empty;
			refetch <= 1'b0;
			cyc_q   <= 1'b0;
		end else if (own_evt && !mount.nonempty) begin
			// Image removed, any cycle in flight is abandoned
			state   <= fdd_empty;
			refetch <= 1'b0;
			cyc_q   <= 1'b0;
		end else begin
			case (state)
				fdd_empty, fdd_loaded: begin
					if (own_evt || ((state == fdd_loaded) && (track != cur_trk))) begin
						state   <= fdd_fetch;
						cyc_q   <= 1'b1;
						adr_q   <= trk_lba;
						cur_trk <= track;
						refetch <= 1'b0;
					end
				end
				fdd_fetch: begin
					if (cyc_q) begin
						// Head moved or new image while the bus is busy
						if (own_evt || (track != cur_trk))
							refetch <= 1'b1;
						if (ack) begin
							cyc_q <= 1'b0;
							if (!refetch && !own_evt && (track == cur_trk))
								state <= fdd_loaded;
						end
					end else begin
						// Idle gap done, fetch the newest track
						cyc_q   <= 1'b1;
						adr_q   <= trk_lba;
						cur_trk <= track;
						refetch <= 1'b0;
					end
				end
				default: state <= fdd_empty;
			endcase
		end
	end

	assign busy  = (state == fdd_fetch);
	assign ready = (state == fdd_loaded);
	assign req   = '{cyc: cyc_q, stb: cyc_q, we: 1'b0, unit: unit, adr: adr_q};

	// An empty drive never holds the bus
	a_no_req_empty: assert property (@(posedge clk_sys) disable iff (dd_reset)
		(state == fdd_empty) |-> !req.cyc);

endmodule

/* hdd_request.sv */
// ==================================================
// Hard disk block master with CPU wait
// ==================================================

`timescale 1ns/100ps
`include "a2_params.svh"

module hdd_request (
	input  logic                     clk_sys,
	input  logic                     dd_reset,
	input  a2_drive_pkg::mount_evt_t mount,
	input  logic                     hdd_read,
	input  logic                     hdd_write,
	input  logic [`A2_LBA_W-1:0]     hdd_sector,
	output a2_bus_pkg::blk_req_t     req,
	input  logic                     ack,
	output logic                     cpu_wait,
	output logic                     hdd_mounted,
	output logic                     hdd_protect
);
	import a2_bus_pkg::*;
	import a2_drive_pkg::*;

	hdd_state_e           state;
	logic                 rd_pend;
	logic                 wr_pend;
	logic                 rd_nxt;
	logic                 wr_nxt;
	logic                 done;
	logic                 cyc_q;
	logic                 we_q;
	logic [`A2_LBA_W-1:0] adr_q;

	assign done = (state == hdd_cycle) && ack;

	// Served command clears on its ack, a fresh pulse sets it again
	assign rd_nxt = (rd_pend && !(done && !we_q)) || hdd_read;
	assign wr_nxt = (wr_pend && !(done && we_q)) || hdd_write;

	// ==================================================
	// Command FSM
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			state    <= hdd_idle;
			rd_pend  <= 1'b0;
			wr_pend  <= 1'b0;
			cyc_q    <= 1'b0;
			we_q     <= 1'b0;
			cpu_wait <= 1'b0;
		end else begin
			rd_pend  <= rd_nxt;
			wr_pend  <= wr_nxt;
			// CPU waits while anything is left to serve
			cpu_wait <= rd_nxt || wr_nxt;
			if (state == hdd_idle) begin
				if (rd_pend || wr_pend) begin
					state <= hdd_cycle;
					cyc_q <= 1'b1;
					// Read goes first when both are pending
					we_q  <= !rd_pend;
					adr_q <= hdd_sector;
				end
			end else if (ack) begin
				state <= hdd_idle;
				cyc_q <= 1'b0;
			end
		end
	end

	// Image status for the hard disk slot only
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			hdd_mounted <= 1'b0;
			hdd_protect <= 1'b0;
		end else if (mount.valid && (mount.unit == unit_hdd)) begin
			hdd_mounted <= mount.nonempty;
			hdd_protect <= mount.readonly;
		end
	end

	assign req = '{cyc: cyc_q, stb: cyc_q, we: we_q, unit: unit_hdd, adr: adr_q};

	// Request frozen until the responder acks
	a_req_stable: assert property (@(posedge clk_sys) disable iff (dd_reset)
		req.stb && !ack |=> $stable(req));

endmodule

/* sim.f */
+incdir+.
a2_bus_pkg.sv
a2_drive_pkg.sv
hdd_request.sv
floppy_track_fetch.sv
blk_arbiter.sv
a2_disk_top.sv
tb_a2_disk.sv

/* tb_a2_disk.sv */
// ==================================================
// Testbench with storage responder and directed tests
// ==================================================

`timescale 1ns/100ps
`include "a2_params.svh"

module tb_a2_disk;
	import a2_bus_pkg::*;
	import a2_drive_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int ACK_LIMIT  = 200;
	// Six tests at up to 400 cycles each plus reset and margin
	localparam int WATCHDOG_NS = 6 * 400 * CLK_PERIOD + 800;

	logic                 clk_sys;
	logic                 dd_reset;
	mount_evt_t           mount;
	logic                 hdd_read;
	logic                 hdd_write;
	logic [`A2_LBA_W-1:0] hdd_sector;
	track_t               track1;
	track_t               track2;
	blk_req_t             blk;
	logic                 blk_ack;
	logic                 cpu_wait;
	logic                 hdd_mounted;
	logic                 hdd_protect;
	logic [1:0]           disk_busy;
	logic [1:0]           disk_ready;

	integer   seed = 90731;
	blk_req_t req_log [$];

	a2_disk_top i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_NS);
		stop_run("Timeout, the directed tests did not finish in time");
	end

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped");
	endtask

	// ==================================================
	// Compare tasks
	// ==================================================
	task automatic check_request(input blk_req_t got, input blk_req_t exp, input string what);
		if (got.unit !== exp.unit || got.we !== exp.we || got.adr !== exp.adr)
			stop_run($sformatf("ERROR at %0t ns: %s, unit %0d we %b adr %0d, expected %0d %b %0d",
				$time, what, got.unit, got.we, got.adr, exp.unit, exp.we, exp.adr));
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_run($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			stop_run($sformatf("ERROR at %0t ns: %s, %0d requests logged, expected %0d",
				$time, what, got, exp));
	endtask

	function automatic blk_req_t bus_cmd(input drive_unit_e unit, input logic we,
		input logic [`A2_LBA_W-1:0] adr);
		bus_cmd = '{cyc: 1'b1, stb: 1'b1, we: we, unit: unit, adr: adr};
	endfunction

	// ==================================================
	// Stimulus helpers
	// ==================================================
	task automatic send_mount(input drive_unit_e unit, input logic nonempty, input logic readonly);
		@(posedge clk_sys);
		mount <= '{valid: 1'b1, unit: unit, nonempty: nonempty, readonly: readonly};
		@(posedge clk_sys);
		mount <= '0;
	endtask

	task automatic pulse_hdd(input logic rd, input logic wr, input logic [`A2_LBA_W-1:0] sector);
		@(posedge clk_sys);
		hdd_sector <= sector;
		hdd_read   <= rd;
		hdd_write  <= wr;
		@(posedge clk_sys);
		hdd_read   <= 1'b0;
		hdd_write  <= 1'b0;
	endtask

	// Counts acks and can require cpu_wait high the whole time
	task automatic wait_acks(input int count, input logic hold_wait);
		int seen;
		int waited;
		seen   = 0;
		waited = 0;
		while (seen < count) begin
			@(posedge clk_sys);
			if (hold_wait)
				check_level(cpu_wait, 1'b1, "cpu_wait while a command is pending");
			if (blk_ack)
				seen++;
			waited++;
			if (waited > ACK_LIMIT)
				stop_run("No ack arrived for a pending bus cycle within the cycle limit");
		end
	endtask

	// Storage responder logs each request and acks after 0 to 5 cycles
	initial begin : responder
		int       delay;
		logic     active;
		logic     gap;
		blk_req_t held;
		blk_ack = 1'b0;
		active  = 1'b0;
		gap     = 1'b0;
		delay   = 0;
		forever begin
			@(posedge clk_sys);
			if (blk_ack) begin
				blk_ack <= 1'b0;
				gap = 1'b1;
			end else if (blk.cyc && blk.stb) begin
				if (gap)
					stop_run("Two bus cycles ran back to back without an idle cycle");
				if (!active) begin
					held   = blk;
					active = 1'b1;
					delay  = $unsigned($random(seed)) % 6;
					req_log.push_back(blk);
				end else if (blk !== held)
					stop_run("A bus request changed before its ack");
				if (delay == 0) begin
					blk_ack <= 1'b1;
					active = 1'b0;
				end else
					delay--;
			end else
				gap = 1'b0;
		end
	end

	// ==================================================
	// Directed tests
	// ==================================================
	task automatic reset_state();
		check_level(blk.cyc, 1'b0, "bus cyc after reset");
		check_level(blk.stb, 1'b0, "bus stb after reset");
		check_level(cpu_wait, 1'b0, "cpu_wait after reset");
		check_level(hdd_mounted, 1'b0, "hdd_mounted after reset");
		check_level(hdd_protect, 1'b0, "hdd_protect after reset");
		for (int i = 0; i < 2; i++) begin
			check_level(disk_busy[i], 1'b0, "disk_busy after reset");
			check_level(disk_ready[i], 1'b0, "disk_ready after reset");
		end
	endtask

	task automatic hdd_single_read();
		int base;
		base = req_log.size();
		send_mount(unit_hdd, 1'b1, 1'b1);
		@(posedge clk_sys);
		check_level(hdd_mounted, 1'b1, "hdd_mounted after mount");
		check_level(hdd_protect, 1'b1, "hdd_protect for a read-only image");
		pulse_hdd(1'b1, 1'b0, 32'h0000_0321);
		wait_acks(1, 1'b1);
		@(posedge clk_sys);
		check_level(cpu_wait, 1'b0, "cpu_wait after the read");
		repeat (8) @(posedge clk_sys);
		check_count(req_log.size() - base, 1, "single read");
		check_request(req_log[base], bus_cmd(unit_hdd, 1'b0, 32'h0000_0321), "read request");
	endtask

	task automatic hdd_read_then_write();
		int base;
		base = req_log.size();
		pulse_hdd(1'b1, 1'b1, 32'h0000_0abc);
		wait_acks(2, 1'b1);
		@(posedge clk_sys);
		check_level(cpu_wait, 1'b0, "cpu_wait after read and write");
		repeat (8) @(posedge clk_sys);
		check_count(req_log.size() - base, 2, "read and write together");
		check_request(req_log[base], bus_cmd(unit_hdd, 1'b0, 32'h0000_0abc),
			"first, the read");
		check_request(req_log[base + 1], bus_cmd(unit_hdd, 1'b1, 32'h0000_0abc),
			"then the write");
	endtask

	task automatic floppy1_mount_step();
		int base;
		base = req_log.size();
		track1 <= track_t'(5);
		send_mount(unit_floppy1, 1'b1, 1'b0);
		@(posedge clk_sys);
		check_level(disk_busy[0], 1'b1, "floppy 1 busy during the fetch");
		wait_acks(1, 1'b0);
		repeat (2) @(posedge clk_sys);
		check_level(disk_ready[0], 1'b1, "floppy 1 ready after the fetch");
		check_level(disk_busy[0], 1'b0, "floppy 1 busy after the fetch");
		track1 <= track_t'(6);
		wait_acks(1, 1'b0);
		repeat (8) @(posedge clk_sys);
		check_level(disk_ready[0], 1'b1, "floppy 1 ready after the step");
		check_count(req_log.size() - base, 2, "floppy 1 mount and step");
		check_request(req_log[base], bus_cmd(unit_floppy1, 1'b0, 5 * `A2_TRACK_BLOCKS),
			"track 5 fetch");
		check_request(req_log[base + 1], bus_cmd(unit_floppy1, 1'b0, 6 * `A2_TRACK_BLOCKS),
			"track 6 fetch");
	endtask

	task automatic floppy2_unmount();
		int base;
		base = req_log.size();
		track2 <= track_t'(2);
		send_mount(unit_floppy2, 1'b1, 1'b0);
		wait_acks(1, 1'b0);
		@(posedge clk_sys);
		check_level(disk_ready[1], 1'b1, "floppy 2 ready before unmount");
		send_mount(unit_floppy2, 1'b0, 1'b0);
		@(posedge clk_sys);
		check_level(disk_ready[1], 1'b0, "floppy 2 ready after unmount");
		track2 <= track_t'(9);
		repeat (20) @(posedge clk_sys);
		check_level(disk_ready[1], 1'b0, "floppy 2 ready after a track change");
		check_count(req_log.size() - base, 1, "floppy 2 unmounted");
		check_request(req_log[base], bus_cmd(unit_floppy2, 1'b0, 2 * `A2_TRACK_BLOCKS),
			"track 2 fetch");
	endtask

	// Hard disk pulse leads by one cycle so all three raise cyc together
	task automatic three_masters();
		int         base;
		logic [2:0] seen;
		blk_req_t   r;
		base = req_log.size();
		seen = '0;
		pulse_hdd(1'b1, 1'b0, 32'h0000_0456);
		track1 <= track_t'(7);
		mount  <= '{valid: 1'b1, unit: unit_floppy2, nonempty: 1'b1, readonly: 1'b0};
		@(posedge clk_sys);
		mount  <= '0;
		wait_acks(3, 1'b0);
		repeat (8) @(posedge clk_sys);
		check_count(req_log.size() - base, 3, "three masters at once");
		for (int i = 0; i < 3; i++) begin
			r = req_log[base + i];
			if (seen[r.unit])
				stop_run("One drive unit was served twice while three masters competed");
			seen[r.unit] = 1'b1;
			case (r.unit)
				unit_floppy1: check_request(r,
					bus_cmd(unit_floppy1, 1'b0, 7 * `A2_TRACK_BLOCKS), "floppy 1 in contention");
				unit_floppy2: check_request(r,
					bus_cmd(unit_floppy2, 1'b0, 9 * `A2_TRACK_BLOCKS), "floppy 2 in contention");
				default: check_request(r,
					bus_cmd(unit_hdd, 1'b0, 32'h0000_0456), "hard disk in contention");
			endcase
		end
		check_level(cpu_wait, 1'b0, "cpu_wait after contention");
	endtask

	initial begin
		mount      = '0;
		hdd_read   = 1'b0;
		hdd_write  = 1'b0;
		hdd_sector = '0;
		track1     = '0;
		track2     = '0;
		dd_reset   = 1'b1;
		repeat (16) @(posedge clk_sys);
		dd_reset <= 1'b0;
		@(posedge clk_sys);
		reset_state();
		hdd_single_read();
		hdd_read_then_write();
		floppy1_mount_step();
		floppy2_unmount();
		three_masters();
		$display("RESULT: PASS");
		$finish;
	end

endmodule
